/* hdl/databus_settings.svh */
`ifndef DATABUS_SETTINGS_SVH
`define DATABUS_SETTINGS_SVH

// IO units sharing the memory path
`define DB_N_IO 3

`define DB_ADDR_W 16
`define DB_DATA_W 32

// Burst length is encoded as beats minus one
`define DB_LEN_W 8

`endif

/* hdl/databus_pkg.sv */
`include "databus_settings.svh"

package databus_pkg;

  // One IO unit request
  // Any set strobe bit marks a write
  typedef struct packed {
    logic [`DB_ADDR_W-1:0]   addr;
    logic [`DB_DATA_W-1:0]   wdata;
    logic [`DB_DATA_W/8-1:0] wstrb;
    logic [`DB_LEN_W-1:0]    len;
  } io_req_t;

  // Memory command channel
  typedef struct packed {
    logic [`DB_ADDR_W-1:0] addr;
    logic [`DB_LEN_W-1:0]  len;
    logic                  write;
  } mem_cmd_t;

  // Write beat toward memory
  typedef struct packed {
    logic [`DB_DATA_W-1:0]   data;
    logic [`DB_DATA_W/8-1:0] strb;
    logic                    last;
  } wbeat_t;

  // Read beat from memory
  typedef struct packed {
    logic [`DB_DATA_W-1:0] data;
    logic                  last;
  } rbeat_t;

endpackage

/* hdl/skid_buffer.sv */
`timescale 1ns/100ps

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic     slot_valid;
  payload_t slot_data;
  logic     in_fire, out_take, slot_next;

  assign in_fire = in_valid && in_ready;
  assign out_take = out_ready || !out_valid; // Output register frees up
  assign slot_next = out_take ? 1'b0 : (slot_valid || in_fire);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      slot_valid <= 1'b0;
      in_ready <= 1'b1;
    end else begin
      if (out_take) begin
        out_valid <= slot_valid || in_fire;
      end
      slot_valid <= slot_next;
      in_ready <= !slot_next;
    end
  end

  // Slot drains first to keep order
  always_ff @(posedge clk) begin
    if (in_fire && !out_take) begin
      slot_data <= in_data;
    end
    if (out_take) begin
      out_data <= slot_valid ? slot_data : in_data;
    end
  end

  // Slot only fills behind a held output
  a_hold: assert property (@(posedge clk) disable iff (rst)
    slot_valid |-> out_valid);

endmodule

/* hdl/databus_merge.sv */
`timescale 1ns/100ps
`include "databus_settings.svh"

module databus_merge import databus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`DB_N_IO-1:0]   io_valid,
  input  io_req_t               io_req [`DB_N_IO],
  output logic [`DB_N_IO-1:0]   io_ready,
  output logic [`DB_N_IO-1:0]   io_last,
  output logic [`DB_DATA_W-1:0] io_rdata,
  output logic                  wr_valid,
  output io_req_t               wr_req,
  input  logic                  wr_ready,
  input  logic                  wr_last,
  output logic                  rd_valid,
  output logic [`DB_ADDR_W-1:0] rd_addr,
  output logic [`DB_LEN_W-1:0]  rd_len,
  input  logic                  rd_ready,
  input  logic                  rd_last,
  input  logic [`DB_DATA_W-1:0] rd_data
);

  localparam int SEL_W = $clog2(`DB_N_IO);

  logic             w_req_any, r_req_any;
  logic [SEL_W-1:0] w_pick, r_pick;
  logic             w_lock, r_lock;
  logic [SEL_W-1:0] w_sel, r_sel;
  logic             w_done, r_done;

  // Later indices overwrite so the highest requester wins
  always_comb begin
    w_req_any = 1'b0;
    r_req_any = 1'b0;
    w_pick = '0;
    r_pick = '0;
    for (int i = 0; i < `DB_N_IO; i++) begin
      if (io_valid[i]) begin
        if (|io_req[i].wstrb) begin
          w_req_any = 1'b1;
          w_pick = SEL_W'(i);
        end else begin
          r_req_any = 1'b1;
          r_pick = SEL_W'(i);
        end
      end
    end
  end

  assign w_done = wr_valid && wr_ready && wr_last;
  assign r_done = rd_valid && rd_ready && rd_last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_lock <= 1'b0;
      r_lock <= 1'b0;
      w_sel <= '0;
      r_sel <= '0;
    end else begin
      if (!w_lock && w_req_any) begin
        w_lock <= 1'b1;
        w_sel <= w_pick;
      end else if (w_done) begin
        w_lock <= 1'b0;
      end
      if (!r_lock && r_req_any) begin
        r_lock <= 1'b1;
        r_sel <= r_pick;
      end else if (r_done) begin
        r_lock <= 1'b0;
      end
    end
  end

  // Ready and last go back to the locked unit only
  always_comb begin
    io_ready = '0;
    io_last = '0;
    wr_valid = 1'b0;
    wr_req = '0;
    rd_valid = 1'b0;
    rd_addr = '0;
    rd_len = '0;
    if (w_lock) begin
      io_ready[w_sel] = wr_ready;
      io_last[w_sel] = wr_last;
      wr_valid = io_valid[w_sel];
      wr_req = io_req[w_sel];
    end
    if (r_lock) begin
      io_ready[r_sel] = rd_ready;
      io_last[r_sel] = rd_last;
      rd_valid = io_valid[r_sel];
      rd_addr = io_req[r_sel].addr;
      rd_len = io_req[r_sel].len;
    end
  end

  assign io_rdata = rd_data; // Shared by all units

  a_wr_hold: assert property (@(posedge clk) disable iff (rst)
    (w_lock ? !w_done : w_req_any) |=> io_valid[w_sel]);

  a_rd_hold: assert property (@(posedge clk) disable iff (rst)
    (r_lock ? !r_done : r_req_any) |=> io_valid[r_sel]);

  // Locked writer still presents a write
  a_wr_lock: assert property (@(posedge clk) disable iff (rst)
    wr_valid |-> |wr_req.wstrb);

endmodule

/* hdl/burst_engine.sv */
`timescale 1ns/100ps
`include "databus_settings.svh"

module burst_engine import databus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_valid,
  input  io_req_t               wr_req,
  output logic                  wr_ready,
  output logic                  wr_last,
  input  logic                  rd_valid,
  input  logic [`DB_ADDR_W-1:0] rd_addr,
  input  logic [`DB_LEN_W-1:0]  rd_len,
  output logic                  rd_ready,
  output logic                  rd_last,
  output logic [`DB_DATA_W-1:0] rd_data,
  output logic                  cmd_valid,
  output mem_cmd_t              cmd,
  input  logic                  cmd_ready,
  output logic                  mem_w_valid,
  output wbeat_t                mem_w,
  input  logic                  mem_w_ready,
  input  logic                  rbeat_in_valid,
  input  rbeat_t                rbeat_in,
  output logic                  rbeat_in_ready
);

  typedef enum logic [1:0] {W_IDLE, W_CMD, W_DATA} w_state_t;
  typedef enum logic [1:0] {R_IDLE, R_CMD, R_DATA} r_state_t;

  w_state_t              w_state;
  r_state_t              r_state;
  logic [`DB_LEN_W-1:0]  w_cnt;
  logic                  cmd_free, w_load, r_load, cmd_fire;
  logic                  w_beat_last, w_fire, r_fire;

  // Shared command register where writes win a tie
  assign cmd_free = !cmd_valid || cmd_ready;
  assign w_load = (w_state == W_IDLE) && wr_valid && cmd_free;
  assign r_load = (r_state == R_IDLE) && rd_valid && cmd_free && !w_load;
  assign cmd_fire = cmd_valid && cmd_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_valid <= 1'b0;
    end else if (w_load || r_load) begin
      cmd_valid <= 1'b1;
    end else if (cmd_ready) begin
      cmd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (w_load) begin
      cmd <= '{addr: wr_req.addr, len: wr_req.len, write: 1'b1};
    end else if (r_load) begin
      cmd <= '{addr: rd_addr, len: rd_len, write: 1'b0};
    end
  end

  // Write path counts its own beats
  assign w_beat_last = (w_cnt == wr_req.len);
  assign mem_w_valid = (w_state == W_DATA) && wr_valid;
  assign wr_ready = (w_state == W_DATA) && mem_w_ready;
  assign wr_last = (w_state == W_DATA) && w_beat_last;
  assign mem_w = '{data: wr_req.wdata, strb: wr_req.wstrb, last: w_beat_last};
  assign w_fire = mem_w_valid && mem_w_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_state <= W_IDLE;
      w_cnt <= '0;
    end else begin
      case (w_state)
        W_IDLE: if (w_load) w_state <= W_CMD;
        W_CMD: if (cmd_fire && cmd.write) w_state <= W_DATA;
        W_DATA: begin
          if (w_fire) begin
            w_cnt <= w_cnt + 1'b1;
            if (w_beat_last) begin
              w_cnt <= '0;
              w_state <= W_IDLE;
            end
          end
        end
        default: w_state <= W_IDLE;
      endcase
    end
  end

  // Reads take last from the memory
  assign rbeat_in_ready = (r_state == R_DATA) && rd_valid;
  assign rd_ready = (r_state == R_DATA) && rbeat_in_valid;
  assign rd_last = (r_state == R_DATA) && rbeat_in.last;
  assign rd_data = rbeat_in.data;
  assign r_fire = rbeat_in_valid && rbeat_in_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      r_state <= R_IDLE;
    end else begin
      case (r_state)
        R_IDLE: if (r_load) r_state <= R_CMD;
        R_CMD: if (cmd_fire && !cmd.write) r_state <= R_DATA;
        R_DATA: if (r_fire && rbeat_in.last) r_state <= R_IDLE;
        default: r_state <= R_IDLE;
      endcase
    end
  end

  // No write beat while a write command still waits in the register
  a_wcmd_first: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid |-> !(cmd_valid && cmd.write));

endmodule

/* hdl/versat_io_top.sv */
`timescale 1ns/100ps
`include "databus_settings.svh"

module versat_io_top import databus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`DB_N_IO-1:0]   io_valid,
  input  io_req_t               io_req [`DB_N_IO],
  output logic [`DB_N_IO-1:0]   io_ready,
  output logic [`DB_N_IO-1:0]   io_last,
  output logic [`DB_DATA_W-1:0] io_rdata,
  output logic                  mem_cmd_valid,
  output mem_cmd_t              mem_cmd,
  input  logic                  mem_cmd_ready,
  output logic                  mem_w_valid,
  output wbeat_t                mem_w,
  input  logic                  mem_w_ready,
  input  logic                  mem_r_valid,
  input  rbeat_t                mem_r,
  output logic                  mem_r_ready
);

  logic                  wr_valid, wr_ready, wr_last;
  io_req_t               wr_req;
  logic                  rd_valid, rd_ready, rd_last;
  logic [`DB_ADDR_W-1:0] rd_addr;
  logic [`DB_LEN_W-1:0]  rd_len;
  logic [`DB_DATA_W-1:0] rd_data;
  logic                  cmd_valid, cmd_ready;
  mem_cmd_t              cmd;
  logic                  rbeat_valid, rbeat_ready;
  rbeat_t                rbeat;

  databus_merge u_merge (
    .clk, .rst,
    .io_valid, .io_req, .io_ready, .io_last, .io_rdata,
    .wr_valid, .wr_req, .wr_ready, .wr_last,
    .rd_valid, .rd_addr, .rd_len, .rd_ready, .rd_last, .rd_data
  );

  burst_engine u_engine (
    .clk, .rst,
    .wr_valid, .wr_req, .wr_ready, .wr_last,
    .rd_valid, .rd_addr, .rd_len, .rd_ready, .rd_last, .rd_data,
    .cmd_valid, .cmd, .cmd_ready,
    .mem_w_valid, .mem_w, .mem_w_ready,
    .rbeat_in_valid(rbeat_valid), .rbeat_in(rbeat), .rbeat_in_ready(rbeat_ready)
  );

  // Outgoing commands
  skid_buffer #(.payload_t(mem_cmd_t)) u_cmd_skid (
    .clk, .rst,
    .in_valid(cmd_valid), .in_data(cmd), .in_ready(cmd_ready),
    .out_valid(mem_cmd_valid), .out_data(mem_cmd), .out_ready(mem_cmd_ready)
  );

  // Returning read beats
  skid_buffer #(.payload_t(rbeat_t)) u_rd_skid (
    .clk, .rst,
    .in_valid(mem_r_valid), .in_data(mem_r), .in_ready(mem_r_ready),
    .out_valid(rbeat_valid), .out_data(rbeat), .out_ready(rbeat_ready)
  );

endmodule

/* tests/mem_model.sv */
`timescale 1ns/100ps
`include "databus_settings.svh"

module mem_model import databus_pkg::*; #(
  parameter int SEED = 44636
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     heavy,
  input  logic     cmd_valid,
  input  mem_cmd_t cmd,
  output logic     cmd_ready,
  input  logic     w_valid,
  input  wbeat_t   w,
  output logic     w_ready,
  output logic     r_valid,
  output rbeat_t   r,
  input  logic     r_ready
);

  logic [`DB_DATA_W-1:0] mem [0:2**`DB_ADDR_W-1];
  mem_cmd_t              wq[$];
  mem_cmd_t              rq[$];
  logic [`DB_ADDR_W-1:0] wcmd_log[$]; // Write command addresses in arrival order
  logic [`DB_ADDR_W-1:0] waddr;
  logic                  r_took;
  int                    seed;
  int                    w_cnt;
  int                    r_cnt;
  int                    w_beats;

  // Mostly ready or mostly stalled when heavy
  function automatic logic coin();
    logic [31:0] v;
    v = $random(seed);
    coin = heavy ? (v[1:0] == 2'd0) : (v[1:0] != 2'd0);
  endfunction

  initial begin
    seed = SEED;
    w_cnt = 0;
    r_cnt = 0;
    w_beats = 0;
    cmd_ready = 1'b0;
    w_ready = 1'b0;
    r_valid = 1'b0;
    r = '0;
    for (int a = 0; a < 2**`DB_ADDR_W; a++) begin
      mem[a] = 32'(a * 3);
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      w_cnt = 0;
      r_cnt = 0;
      #1;
      cmd_ready = 1'b0;
      w_ready = 1'b0;
      r_valid = 1'b0;
    end else begin
      r_took = r_valid && r_ready;
      if (cmd_valid && cmd_ready) begin
        if (cmd.write) begin
          wq.push_back(cmd);
          wcmd_log.push_back(cmd.addr);
        end else begin
          rq.push_back(cmd);
        end
      end
      if (w_valid && w_ready) begin
        waddr = wq[0].addr + 16'(w_cnt);
        for (int b = 0; b < `DB_DATA_W/8; b++) begin
          if (w.strb[b]) mem[waddr][b*8 +: 8] = w.data[b*8 +: 8];
        end
        w_beats++;
        if (w_cnt == int'(wq[0].len)) begin
          void'(wq.pop_front());
          w_cnt = 0;
        end else begin
          w_cnt++;
        end
      end
      if (r_took) begin
        if (r_cnt == int'(rq[0].len)) begin
          void'(rq.pop_front());
          r_cnt = 0;
        end else begin
          r_cnt++;
        end
      end
      #1;
      cmd_ready = coin();
      w_ready = (wq.size() != 0) && coin(); // No beats before their command
      if (!r_valid || r_took) begin
        if (rq.size() != 0 && coin()) begin
          r_valid = 1'b1;
          r = '{data: mem[rq[0].addr + 16'(r_cnt)], last: (r_cnt == int'(rq[0].len))};
        end else begin
          r_valid = 1'b0;
        end
      end
    end
  end

endmodule

/* tests/versat_io_tb.sv */
`timescale 1ns/100ps
`include "databus_settings.svh"

module versat_io_tb import databus_pkg::*; ();

  localparam int N = `DB_N_IO;
  localparam int TOTAL_BEATS = 40;
  localparam int LIMIT = TOTAL_BEATS * 20 + 200;

  logic                  clk;
  logic                  rst;
  logic [N-1:0]          io_valid;
  io_req_t               io_req [N];
  logic [N-1:0]          io_ready;
  logic [N-1:0]          io_last;
  logic [`DB_DATA_W-1:0] io_rdata;
  logic                  mem_cmd_valid, mem_cmd_ready;
  mem_cmd_t              mem_cmd;
  logic                  mem_w_valid, mem_w_ready;
  wbeat_t                mem_w;
  logic                  mem_r_valid, mem_r_ready;
  rbeat_t                mem_r;
  logic                  stall_heavy;

  // Expected state per unit from the burst drivers
  logic [N-1:0]          wr_units;
  logic [N-1:0]          exp_last;
  logic [`DB_DATA_W-1:0] exp_rd [N];
  logic [`DB_DATA_W-1:0] shadow [0:2**`DB_ADDR_W-1];
  logic                  seen_req;
  int                    errors;
  int                    tests;
  int                    cycles;
  int                    base;

  versat_io_top i_dut (
    .clk, .rst,
    .io_valid, .io_req, .io_ready, .io_last, .io_rdata,
    .mem_cmd_valid, .mem_cmd, .mem_cmd_ready,
    .mem_w_valid, .mem_w, .mem_w_ready,
    .mem_r_valid, .mem_r, .mem_r_ready
  );

  mem_model #(.SEED(44636)) i_mem (
    .clk, .rst, .heavy(stall_heavy),
    .cmd_valid(mem_cmd_valid), .cmd(mem_cmd), .cmd_ready(mem_cmd_ready),
    .w_valid(mem_w_valid), .w(mem_w), .w_ready(mem_w_ready),
    .r_valid(mem_r_valid), .r(mem_r), .r_ready(mem_r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  a_quiet: assert property (@(posedge clk) disable iff (rst)
    !seen_req |-> io_ready == '0 && !mem_cmd_valid && !mem_w_valid && mem_r_ready)
    else begin
      errors++;
      $display({"CHECK FAILED io_ready/mem_cmd_valid/mem_w_valid/mem_r_ready",
        " expected 0/0/0/1 got %h/%h/%h/%h"},
        io_ready, mem_cmd_valid, mem_w_valid, mem_r_ready);
    end

  a_one_writer: assert property (@(posedge clk) disable iff (rst)
    $onehot0(io_ready & wr_units))
    else begin
      errors++;
      $display("CHECK FAILED io_ready expected one writer got %h", io_ready & wr_units);
    end

  // Memory side last follows the writing unit's own beat count
  a_mem_wlast: assert property (@(posedge clk) disable iff (rst)
    mem_w_valid && mem_w_ready |-> mem_w.last == |(exp_last & wr_units & io_ready))
    else begin
      errors++;
      $display("CHECK FAILED mem_w.last expected %h got %h",
        $sampled(|(exp_last & wr_units & io_ready)), $sampled(mem_w.last));
    end

  for (genvar u = 0; u < N; u++) begin : g_unit
    a_io_last: assert property (@(posedge clk) disable iff (rst)
      io_valid[u] && io_ready[u] |-> io_last[u] == exp_last[u])
      else begin
        errors++;
        $display("CHECK FAILED io_last[%0d] expected %h got %h", u, exp_last[u], io_last[u]);
      end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
      io_valid[u] && io_ready[u] && !wr_units[u] |-> io_rdata == exp_rd[u])
      else begin
        errors++;
        $display("CHECK FAILED io_rdata unit %0d expected %h got %h", u, exp_rd[u], io_rdata);
      end
  end

  // Holds valid and request until the final beat with new write data per beat
  task automatic run_burst(input int u, input bit write, input logic [`DB_ADDR_W-1:0] addr,
                           input logic [`DB_LEN_W-1:0] len, input logic [`DB_DATA_W-1:0] d0);
    int                    k;
    logic [`DB_DATA_W-1:0] d;
    k = 0;
    d = d0;
    wr_units[u] = write;
    exp_last[u] = (len == 0);
    exp_rd[u] = shadow[addr];
    io_req[u] = '{addr: addr, wdata: write ? d : '0, wstrb: write ? 4'hf : 4'h0, len: len};
    io_valid[u] = 1'b1;
    seen_req = 1'b1;
    while (k <= int'(len)) begin
      @(posedge clk);
      if (io_valid[u] && io_ready[u]) begin
        if (write) shadow[addr + 16'(k)] = d;
        k++;
      end
      #1;
      if (k > int'(len)) begin
        io_valid[u] = 1'b0;
        wr_units[u] = 1'b0;
      end else begin
        exp_last[u] = (k == int'(len));
        d = d + 32'h0101_0101;
        io_req[u].wdata = write ? d : '0;
        exp_rd[u] = shadow[addr + 16'(k)];
      end
    end
  endtask

  task automatic check_mem(input logic [`DB_ADDR_W-1:0] addr, input int n);
    logic [`DB_ADDR_W-1:0] a;
    for (int i = 0; i < n; i++) begin
      a = addr + 16'(i);
      assert (i_mem.mem[a] == shadow[a])
        else begin
          errors++;
          $display("CHECK FAILED mem[%h] expected %h got %h", a, shadow[a], i_mem.mem[a]);
        end
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d (%s) done, %0d errors so far", tests, name, errors);
  endtask

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    io_valid = '0;
    stall_heavy = 1'b0;
    wr_units = '0;
    exp_last = '0;
    seen_req = 1'b0;
    errors = 0;
    tests = 0;
    for (int u = 0; u < N; u++) begin
      io_req[u] = '0;
      exp_rd[u] = '0;
    end
    for (int a = 0; a < 2**`DB_ADDR_W; a++) begin
      shadow[a] = 32'(a * 3); // Memory starts at address times 3
    end
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;

    repeat (10) @(posedge clk);
    #1;
    end_test("after reset");

    run_burst(0, 1'b1, 16'h0100, 8'd3, 32'ha000_0000);
    check_mem(16'h0100, 4);
    end_test("single write");

    run_burst(1, 1'b0, 16'h0200, 8'd3, '0);
    end_test("single read");

    base = i_mem.wcmd_log.size();
    fork
      run_burst(0, 1'b1, 16'h0300, 8'd3, 32'hb000_0000);
      run_burst(2, 1'b1, 16'h0400, 8'd3, 32'hc000_0000);
    join
    assert (i_mem.wcmd_log[base] == 16'h0400)
      else begin
        errors++;
        $display("CHECK FAILED first write addr expected %h got %h", 16'h0400,
          i_mem.wcmd_log[base]);
      end
    check_mem(16'h0300, 4);
    check_mem(16'h0400, 4);
    end_test("priority");

    fork
      run_burst(0, 1'b0, 16'h0500, 8'd3, '0);
      run_burst(1, 1'b1, 16'h0600, 8'd3, 32'hd000_0000);
    join
    check_mem(16'h0600, 4);
    end_test("parallel read and write");

    stall_heavy = 1'b1;
    fork
      run_burst(2, 1'b1, 16'h0700, 8'd7, 32'he000_0000);
      run_burst(1, 1'b0, 16'h0800, 8'd7, '0);
    join
    check_mem(16'h0700, 8);
    assert (i_mem.w_beats == 24)
      else begin
        errors++;
        $display("CHECK FAILED write beat count expected %h got %h", 24, i_mem.w_beats);
      end
    end_test("back-pressure");

    $display("Tests run: %0d, checks failed: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* versat_io_top.f */
+incdir+hdl
hdl/databus_pkg.sv
hdl/skid_buffer.sv
hdl/databus_merge.sv
hdl/burst_engine.sv
hdl/versat_io_top.sv
tests/mem_model.sv
tests/versat_io_tb.sv

/* Makefile */
TOOL  ?= verilator
FLAGS ?= --binary --timing --assert
TOP   ?= versat_io_tb
FLIST ?= versat_io_top.f
OBJ   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ)
